// File: src/s1c88_pkg.sv
package s1c88_pkg;

    typedef logic [23:0] addr_t;
    typedef logic [7:0]  byte_t;

    // signals the core drives on its external bus
    typedef struct packed {
        addr_t address;
        byte_t wdata;
        logic  read;
        logic  write;
        // high with read in the first clock of an opcode fetch
        logic  sync;
    } bus_req_t;

    // move endpoints used by the micro program
    typedef enum logic [2:0] {
        MOV_NONE     = 3'd0,
        MOV_IMM_LOW  = 3'd1,
        MOV_IMM_HIGH = 3'd2,
        MOV_MEM      = 3'd3,
        MOV_A        = 3'd4,
        MOV_BR       = 3'd5,
        MOV_EP       = 3'd6
    } mov_reg_e;

    // data address forms, {EP, BR, ll} or {EP, hh, ll}
    typedef enum logic {
        ADDR_BR_LL = 1'b0,
        ADDR_HH_LL = 1'b1
    } addr_mode_e;

    typedef struct packed {
        logic       is_bus;
        logic       bus_write;
        addr_mode_e addr_mode;
        mov_reg_e   dst;
        mov_reg_e   src;
        logic       done;
        logic       spare;
    } micro_word_t;

    typedef struct packed {
        logic     enable;
        mov_reg_e dst;
        byte_t    value;
    } reg_write_t;

    // 0xCE and 0xCF both prefix an extension byte
    localparam byte_t OPCODE_PREFIX_LOW = 8'hCE;

    localparam addr_t RESET_VECTOR_LOW  = 24'h000000;
    localparam addr_t RESET_VECTOR_HIGH = 24'h000001;
    localparam addr_t DUMMY_ADDRESS     = 24'hDEFACE;

    localparam int MICRO_DEPTH = 32;
    // three pages of 256, plain opcodes then the CE and CF pages
    localparam int XLATE_DEPTH = 768;

endpackage

// File: src/opcode_decode.sv
module opcode_decode
(
    input  s1c88_pkg::byte_t opcode,
    input  s1c88_pkg::byte_t opext,
    output logic             need_opext,
    output logic             need_imm,
    output logic             imm_size
);

    always_comb
    begin
        // CE and CF differ only in bit 0
        need_opext = ((opcode | 8'h01) == (s1c88_pkg::OPCODE_PREFIX_LOW | 8'h01));
        need_imm   = 1'b0;
        imm_size   = 1'b0;

        if (need_opext)
        begin
            case ({opcode[0], opext})
                // LD EP,#nn
                9'h0C5:
                    need_imm = 1'b1;
                // LD A,[hhll]
                9'h0D0:
                begin
                    need_imm = 1'b1;
                    imm_size = 1'b1;
                end
                default:
                begin
                end
            endcase
        end
        else
        begin
            case (opcode)
                // LD BR,#nn / LD A,[BR:ll] / LD [BR:ll],A
                8'hB4, 8'h44, 8'h7C:
                    need_imm = 1'b1;
                // LD [BR:ll],#nn
                8'hDD:
                begin
                    need_imm = 1'b1;
                    imm_size = 1'b1;
                end
                default:
                begin
                end
            endcase
        end
    end

endmodule

// File: src/microcode_rom.sv
module microcode_rom
(
    input  logic [9:0]               extended_opcode,
    input  logic [1:0]               micro_step,
    output s1c88_pkg::micro_word_t   micro
);

    localparam int ADDR_W = $clog2(s1c88_pkg::MICRO_DEPTH);

    logic [ADDR_W-1:0]     xlate [s1c88_pkg::XLATE_DEPTH];
    s1c88_pkg::micro_word_t rom  [s1c88_pkg::MICRO_DEPTH];
    logic [ADDR_W-1:0]     micro_address;

    function automatic s1c88_pkg::micro_word_t make_word
    (
        input logic                  is_bus,
        input logic                  bus_write,
        input s1c88_pkg::addr_mode_e mode,
        input s1c88_pkg::mov_reg_e   dst,
        input s1c88_pkg::mov_reg_e   src
    );
        s1c88_pkg::micro_word_t w;
        w.is_bus    = is_bus;
        w.bus_write = bus_write;
        w.addr_mode = mode;
        w.dst       = dst;
        w.src       = src;
        // every program here is a single word
        w.done      = 1'b1;
        w.spare     = 1'b0;
        return w;
    endfunction

    initial
    begin
        for (int i = 0; i < s1c88_pkg::XLATE_DEPTH; i++)
            xlate[i] = '0;
        for (int i = 0; i < s1c88_pkg::MICRO_DEPTH; i++)
            rom[i] = '0;

        // address 0 is the no-op that unknown opcodes land on
        rom[0] = make_word(1'b0, 1'b0, s1c88_pkg::ADDR_BR_LL, s1c88_pkg::MOV_NONE,
                           s1c88_pkg::MOV_NONE);
        rom[1] = make_word(1'b1, 1'b0, s1c88_pkg::ADDR_BR_LL, s1c88_pkg::MOV_A,
                           s1c88_pkg::MOV_MEM);
        rom[2] = make_word(1'b1, 1'b0, s1c88_pkg::ADDR_HH_LL, s1c88_pkg::MOV_A,
                           s1c88_pkg::MOV_MEM);
        rom[3] = make_word(1'b0, 1'b0, s1c88_pkg::ADDR_BR_LL, s1c88_pkg::MOV_EP,
                           s1c88_pkg::MOV_IMM_LOW);
        rom[4] = make_word(1'b0, 1'b0, s1c88_pkg::ADDR_BR_LL, s1c88_pkg::MOV_BR,
                           s1c88_pkg::MOV_IMM_LOW);
        // stores take the byte to write from src
        rom[5] = make_word(1'b1, 1'b1, s1c88_pkg::ADDR_BR_LL, s1c88_pkg::MOV_MEM,
                           s1c88_pkg::MOV_IMM_HIGH);
        rom[6] = make_word(1'b1, 1'b1, s1c88_pkg::ADDR_BR_LL, s1c88_pkg::MOV_MEM,
                           s1c88_pkg::MOV_A);

        xlate[10'h044] = ADDR_W'(1);
        xlate[10'h1D0] = ADDR_W'(2);
        xlate[10'h1C5] = ADDR_W'(3);
        xlate[10'h0B4] = ADDR_W'(4);
        xlate[10'h0DD] = ADDR_W'(5);
        xlate[10'h07C] = ADDR_W'(6);
    end

    assign micro_address = xlate[extended_opcode] + {{(ADDR_W-2){1'b0}}, micro_step};
    assign micro         = rom[micro_address];

endmodule

// File: src/bus_sequencer.sv
module bus_sequencer
(
    input  logic                    clk,
    input  logic                    reset,
    input  s1c88_pkg::byte_t        data_in,
    output s1c88_pkg::bus_req_t     bus,
    output s1c88_pkg::byte_t        opcode,
    output s1c88_pkg::byte_t        opext,
    input  logic                    need_opext,
    input  logic                    need_imm,
    input  logic                    imm_size,
    output logic [1:0]              micro_step,
    input  s1c88_pkg::micro_word_t  micro,
    input  s1c88_pkg::byte_t        a,
    input  s1c88_pkg::byte_t        br,
    input  s1c88_pkg::byte_t        ep,
    output s1c88_pkg::reg_write_t   reg_write
);

    typedef enum logic [2:0] {
        ST_RESET_WAIT, ST_VECTOR, ST_FETCH, ST_OPEXT, ST_IMM_LOW, ST_IMM_HIGH, ST_EXECUTE
    } state_e;

    state_e                 state;
    state_e                 next_state;
    // low in the first clock of a bus cycle, high in the second
    logic                   phase;
    // counts the idle cycles and then the two vector bytes
    logic                   step_cnt;
    logic [15:0]            pc;
    logic [15:0]            fetch_addr;
    s1c88_pkg::byte_t       opcode_q;
    s1c88_pkg::byte_t       opext_q;
    s1c88_pkg::byte_t       imm_low_q;
    s1c88_pkg::byte_t       imm_high_q;
    s1c88_pkg::byte_t       imm_low_v;
    s1c88_pkg::byte_t       imm_high_v;
    s1c88_pkg::byte_t       src_value;
    s1c88_pkg::addr_t       data_address;
    s1c88_pkg::micro_word_t exec_q;
    s1c88_pkg::bus_req_t    next_req;
    logic                   take_micro;
    logic                   program_read;

    // the byte arriving now stands in for its latch, so decode and moves see it at once
    assign opcode     = (state == ST_FETCH) ? data_in : opcode_q;
    assign opext      = (state == ST_OPEXT) ? data_in : opext_q;
    assign imm_low_v  = (state == ST_IMM_LOW) ? data_in : imm_low_q;
    assign imm_high_v = (state == ST_IMM_HIGH) ? data_in : imm_high_q;
    assign fetch_addr = (state == ST_VECTOR) ? {data_in, pc[7:0]} : pc;

    assign data_address = (micro.addr_mode == s1c88_pkg::ADDR_HH_LL) ?
                          {ep, imm_high_v, imm_low_v} : {ep, br, imm_low_v};

    assign program_read = next_state inside {ST_FETCH, ST_OPEXT, ST_IMM_LOW, ST_IMM_HIGH};

    // the micro word is taken once the last program byte is in
    always_comb
    begin
        case (state)
            ST_FETCH:    take_micro = !need_opext && !need_imm;
            ST_OPEXT:    take_micro = !need_imm;
            ST_IMM_LOW:  take_micro = !imm_size;
            ST_IMM_HIGH: take_micro = 1'b1;
            ST_EXECUTE:  take_micro = !exec_q.done;
            default:     take_micro = 1'b0;
        endcase
    end

    always_comb
    begin
        case (micro.src)
            s1c88_pkg::MOV_IMM_LOW:  src_value = imm_low_v;
            s1c88_pkg::MOV_IMM_HIGH: src_value = imm_high_v;
            s1c88_pkg::MOV_MEM:      src_value = data_in;
            s1c88_pkg::MOV_A:        src_value = a;
            s1c88_pkg::MOV_BR:       src_value = br;
            s1c88_pkg::MOV_EP:       src_value = ep;
            default:                 src_value = 8'h00;
        endcase
    end

    // next bus cycle, loaded at the end of the current one
    always_comb
    begin
        next_state = state;
        next_req   = '{address: {8'h00, fetch_addr}, wdata: bus.wdata,
                       read: 1'b1, write: 1'b0, sync: 1'b0};
        case (state)
            ST_RESET_WAIT:
            begin
                if (!step_cnt)
                begin
                    next_req.address = s1c88_pkg::DUMMY_ADDRESS;
                    next_req.read    = 1'b0;
                end
                else
                begin
                    next_state       = ST_VECTOR;
                    next_req.address = s1c88_pkg::RESET_VECTOR_LOW;
                end
            end
            ST_VECTOR:
            begin
                if (!step_cnt)
                    next_req.address = s1c88_pkg::RESET_VECTOR_HIGH;
                else
                    next_state = ST_FETCH;
            end
            ST_FETCH:
                next_state = need_opext ? ST_OPEXT : ST_IMM_LOW;
            ST_OPEXT:
                next_state = ST_IMM_LOW;
            ST_IMM_LOW:
                next_state = ST_IMM_HIGH;
            default:
                next_state = ST_FETCH;
        endcase

        if (take_micro)
        begin
            if (micro.is_bus)
            begin
                next_state       = ST_EXECUTE;
                next_req.address = data_address;
                next_req.read    = !micro.bus_write;
                next_req.write   = micro.bus_write;
                next_req.wdata   = src_value;
            end
            else
            begin
                next_state = ST_FETCH;
            end
        end
        next_req.sync = (next_state == ST_FETCH);
    end

    always_comb
    begin
        reg_write = '0;
        if (phase && state == ST_EXECUTE && !exec_q.bus_write &&
            exec_q.dst != s1c88_pkg::MOV_NONE)
        begin
            reg_write.enable = 1'b1;
            reg_write.dst    = exec_q.dst;
            reg_write.value  = data_in;
        end
        else if (phase && take_micro && !micro.is_bus && micro.dst != s1c88_pkg::MOV_NONE)
        begin
            reg_write.enable = 1'b1;
            reg_write.dst    = micro.dst;
            reg_write.value  = src_value;
        end
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            state      <= ST_RESET_WAIT;
            phase      <= 1'b0;
            step_cnt   <= 1'b0;
            micro_step <= 2'd0;
            pc         <= 16'h0000;
            bus        <= '{address: '1, default: '0};
        end
        else
        begin
            phase <= !phase;
            if (!phase)
            begin
                // strobes only last the first clock
                bus.read  <= 1'b0;
                bus.write <= 1'b0;
                bus.sync  <= 1'b0;
            end
            else
            begin
                state <= next_state;
                bus   <= next_req;
                if (state == ST_RESET_WAIT || state == ST_VECTOR)
                    step_cnt <= !step_cnt;
                if (state == ST_VECTOR && !step_cnt)
                    pc[7:0] <= data_in;
                else if (program_read)
                    pc <= fetch_addr + 16'd1;
                if (next_state == ST_FETCH)
                    micro_step <= 2'd0;
                else if (take_micro)
                    micro_step <= micro_step + 2'd1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (phase)
        begin
            case (state)
                ST_FETCH:    opcode_q   <= data_in;
                ST_OPEXT:    opext_q    <= data_in;
                ST_IMM_LOW:  imm_low_q  <= data_in;
                ST_IMM_HIGH: imm_high_q <= data_in;
                default:
                begin
                end
            endcase
            if (take_micro && micro.is_bus)
                exec_q <= micro;
        end
    end

    // a strobe lasts one clock and read never meets write
    a_strobe: assert property (@(posedge clk) disable iff (reset)
        (bus.read || bus.write) |-> !(bus.read && bus.write) ##1 !(bus.read || bus.write));

    a_sync_read: assert property (@(posedge clk) disable iff (reset)
        bus.sync |-> bus.read);

    // register-only words must close the program and never follow a data cycle
    a_reg_word_last: assert property (@(posedge clk) disable iff (reset)
        (phase && take_micro && !micro.is_bus) |-> micro.done && state != ST_EXECUTE);

endmodule

// File: src/register_file.sv
module register_file
(
    input  logic                  clk,
    input  logic                  reset,
    input  s1c88_pkg::reg_write_t reg_write,
    output s1c88_pkg::byte_t      a,
    output s1c88_pkg::byte_t      br,
    output s1c88_pkg::byte_t      ep
);

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            a  <= 8'h00;
            br <= 8'h00;
            ep <= 8'h00;
        end
        else if (reg_write.enable)
        begin
            case (reg_write.dst)
                s1c88_pkg::MOV_A:  a  <= reg_write.value;
                s1c88_pkg::MOV_BR: br <= reg_write.value;
                s1c88_pkg::MOV_EP: ep <= reg_write.value;
                default:
                begin
                end
            endcase
        end
    end

    // micro program and sequencer must only ever target a real register
    a_write_target: assert property (@(posedge clk) disable iff (reset)
        reg_write.enable |->
            !(reg_write.dst inside {s1c88_pkg::MOV_NONE, s1c88_pkg::MOV_IMM_LOW,
                                    s1c88_pkg::MOV_IMM_HIGH}));

endmodule

// File: src/s1c88_core.sv
module s1c88_core
(
    input  logic                clk,
    input  logic                reset,
    input  s1c88_pkg::byte_t    data_in,
    output s1c88_pkg::bus_req_t bus
);

    s1c88_pkg::byte_t       opcode;
    s1c88_pkg::byte_t       opext;
    logic                   need_opext;
    logic                   need_imm;
    logic                   imm_size;
    logic [1:0]             micro_step;
    s1c88_pkg::micro_word_t micro;
    s1c88_pkg::byte_t       a;
    s1c88_pkg::byte_t       br;
    s1c88_pkg::byte_t       ep;
    s1c88_pkg::reg_write_t  reg_write;
    s1c88_pkg::byte_t       prefix_index;
    logic [9:0]             extended_opcode;

    // CE selects page 1 of the translation table, CF page 2
    assign prefix_index    = opcode - s1c88_pkg::OPCODE_PREFIX_LOW + 8'd1;
    assign extended_opcode = need_opext ? {prefix_index[1:0], opext} : {2'b00, opcode};

    opcode_decode i_decode
    (
        .opcode     (opcode),
        .opext      (opext),
        .need_opext (need_opext),
        .need_imm   (need_imm),
        .imm_size   (imm_size)
    );

    microcode_rom i_microcode
    (
        .extended_opcode (extended_opcode),
        .micro_step      (micro_step),
        .micro           (micro)
    );

    bus_sequencer i_sequencer
    (
        .clk        (clk),
        .reset      (reset),
        .data_in    (data_in),
        .bus        (bus),
        .opcode     (opcode),
        .opext      (opext),
        .need_opext (need_opext),
        .need_imm   (need_imm),
        .imm_size   (imm_size),
        .micro_step (micro_step),
        .micro      (micro),
        .a          (a),
        .br         (br),
        .ep         (ep),
        .reg_write  (reg_write)
    );

    register_file i_regs
    (
        .clk       (clk),
        .reset     (reset),
        .reg_write (reg_write),
        .a         (a),
        .br        (br),
        .ep        (ep)
    );

endmodule

// File: test/tb_clock.sv
module tb_clock
(
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam time HALF_PERIOD = 4ns;

    initial
    begin
        clk   = 1'b0;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

endmodule

// File: test/tb_s1c88.sv
module tb_s1c88;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int PROGRAM_LENGTH = 60;
    localparam int DRAIN_TIMEOUT  = 4000;

    logic                clk;
    logic                reset;
    s1c88_pkg::byte_t    data_in;
    s1c88_pkg::bus_req_t bus;

    // memory seen by the DUT and the copy the instruction model runs on
    logic [7:0]          mem       [65536];
    logic [7:0]          model_mem [65536];

    s1c88_pkg::bus_req_t expected_q[$];
    integer              seed;
    int                  error_count;
    int                  checked_count;
    int                  cycles;
    logic [15:0]         gen_pc;
    logic [15:0]         model_pc;
    logic [7:0]          model_a;
    logic [7:0]          model_br;
    logic [7:0]          model_ep;

    tb_clock i_clock
    (
        .clk   (clk),
        .reset (reset)
    );

    s1c88_core i_dut
    (
        .clk     (clk),
        .reset   (reset),
        .data_in (data_in),
        .bus     (bus)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            error_count++;
            $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic put_byte(input logic [7:0] value);
        mem[gen_pc] = value;
        gen_pc      = gen_pc + 16'd1;
    endtask

    task automatic push_read(input s1c88_pkg::addr_t address, input logic sync);
        s1c88_pkg::bus_req_t t;
        t         = '0;
        t.address = address;
        t.read    = 1'b1;
        t.sync    = sync;
        expected_q.push_back(t);
    endtask

    task automatic push_write(input s1c88_pkg::addr_t address, input logic [7:0] value);
        s1c88_pkg::bus_req_t t;
        t         = '0;
        t.address = address;
        t.write   = 1'b1;
        t.wdata   = value;
        expected_q.push_back(t);
    endtask

    // reads one program byte at PC and moves PC on
    task automatic read_program(input logic sync, output logic [7:0] value);
        push_read({8'h00, model_pc}, sync);
        value    = model_mem[model_pc];
        model_pc = model_pc + 16'd1;
    endtask

    task automatic write_program();
        logic [31:0] r;
        logic [7:0]  op;
        gen_pc = 16'h0100;
        for (int n = 0; n < PROGRAM_LENGTH; n++)
        begin
            r = $random(seed);
            case (r[2:0])
                3'd0:
                begin
                    put_byte(8'hCE);
                    put_byte(8'hC5);
                    put_byte(r[15:8]);
                end
                3'd1:
                begin
                    put_byte(8'hB4);
                    // BR stays in the upper half of memory so stores never land on the program
                    put_byte({1'b1, r[14:8]});
                end
                3'd2:
                begin
                    put_byte(8'h44);
                    put_byte(r[15:8]);
                end
                3'd3:
                begin
                    put_byte(8'hCE);
                    put_byte(8'hD0);
                    put_byte(r[15:8]);
                    put_byte(r[23:16]);
                end
                3'd4:
                begin
                    put_byte(8'hDD);
                    put_byte(r[15:8]);
                    put_byte(r[23:16]);
                end
                3'd5:
                begin
                    put_byte(8'h7C);
                    put_byte(r[15:8]);
                end
                default:
                begin
                    op = r[15:8];
                    if (op inside {8'hCE, 8'hCF, 8'hB4, 8'h44, 8'hDD, 8'h7C})
                        op = 8'h00;
                    put_byte(op);
                end
            endcase
        end
    endtask

    // instruction level model that expands each instruction into its bus transactions
    task automatic run_model();
        logic [7:0] op;
        logic [7:0] ext;
        logic [7:0] lo;
        logic [7:0] hi;
        model_a  = 8'h00;
        model_br = 8'h00;
        model_ep = 8'h00;
        push_read(24'h000000, 1'b0);
        push_read(24'h000001, 1'b0);
        model_pc = {model_mem[1], model_mem[0]};
        for (int n = 0; n < PROGRAM_LENGTH; n++)
        begin
            read_program(1'b1, op);
            case (op)
                8'hCE, 8'hCF:
                begin
                    read_program(1'b0, ext);
                    if (op == 8'hCE && ext == 8'hC5)
                    begin
                        read_program(1'b0, lo);
                        model_ep = lo;
                    end
                    else if (op == 8'hCE && ext == 8'hD0)
                    begin
                        read_program(1'b0, lo);
                        read_program(1'b0, hi);
                        push_read({model_ep, hi, lo}, 1'b0);
                        model_a = model_mem[{hi, lo}];
                    end
                end
                8'hB4:
                begin
                    read_program(1'b0, lo);
                    model_br = lo;
                end
                8'h44:
                begin
                    read_program(1'b0, lo);
                    push_read({model_ep, model_br, lo}, 1'b0);
                    model_a = model_mem[{model_br, lo}];
                end
                8'hDD:
                begin
                    read_program(1'b0, lo);
                    read_program(1'b0, hi);
                    push_write({model_ep, model_br, lo}, hi);
                    model_mem[{model_br, lo}] = hi;
                end
                8'h7C:
                begin
                    read_program(1'b0, lo);
                    push_write({model_ep, model_br, lo}, model_a);
                    model_mem[{model_br, lo}] = model_a;
                end
                default:
                begin
                end
            endcase
        end
        // fetch of the byte after the program closes the expected stream
        push_read({8'h00, model_pc}, 1'b1);
    endtask

    task automatic compare_transaction();
        s1c88_pkg::bus_req_t exp;
        string               tag;
        if (expected_q.size() == 0)
        begin
            error_count++;
            $display("bus transaction at address %06h arrived when none was expected",
                     bus.address);
        end
        else
        begin
            exp = expected_q.pop_front();
            tag = $sformatf("transaction %0d", checked_count);
            check_value({tag, " address"}, {8'h00, exp.address}, {8'h00, bus.address});
            check_value({tag, " read"}, 32'(exp.read), 32'(bus.read));
            check_value({tag, " write"}, 32'(exp.write), 32'(bus.write));
            check_value({tag, " sync"}, 32'(exp.sync), 32'(bus.sync));
            if (exp.write)
                check_value({tag, " write data"}, 32'(exp.wdata), 32'(bus.wdata));
            checked_count++;
        end
    endtask

    // memory takes stores and presents read data for the second clock of a cycle
    always @(posedge clk)
    begin
        if (bus.write)
            mem[bus.address[15:0]] = bus.wdata;
        data_in <= mem[bus.address[15:0]];
    end

    // a strobe marks the first clock of a transaction
    always @(negedge clk)
    begin
        if (reset === 1'b0 && (bus.read || bus.write))
            compare_transaction();
    end

    initial
    begin
        logic [31:0] r;
        data_in       = 8'h00;
        seed          = 32'he5ecdbfe;
        error_count   = 0;
        checked_count = 0;

        for (int i = 0; i < 65536; i++)
        begin
            r      = $random(seed);
            mem[i] = r[7:0];
        end
        mem[0] = 8'h00;
        mem[1] = 8'h01;
        write_program();
        model_mem = mem;
        run_model();

        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (reset !== 1'b1 && cycles < 4);
        if (reset !== 1'b1)
        begin
            error_count++;
            $display("reset was never asserted");
        end
        else
        begin
            check_value("reset address", 32'h00FFFFFF, {8'h00, bus.address});
            check_value("reset read", 32'h0, 32'(bus.read));
            check_value("reset write", 32'h0, 32'(bus.write));
            check_value("reset sync", 32'h0, 32'(bus.sync));
        end

        cycles = 0;
        while (reset !== 1'b0 && cycles < 20)
        begin
            @(posedge clk);
            cycles++;
        end
        if (reset !== 1'b0)
        begin
            error_count++;
            $display("reset was not released within 20 cycles");
        end

        cycles = 0;
        while (expected_q.size() != 0 && cycles < DRAIN_TIMEOUT)
        begin
            @(posedge clk);
            cycles++;
        end
        if (expected_q.size() != 0)
        begin
            error_count++;
            $display("timed out with %0d bus transactions still expected", expected_q.size());
        end

        // the monitor still watches the second clock of the closing fetch for a stray strobe
        @(posedge clk);

        $display("checked %0d transactions, %0d errors", checked_count, error_count);
        if (error_count == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: tb.f
src/s1c88_pkg.sv
src/opcode_decode.sv
src/microcode_rom.sv
src/bus_sequencer.sv
src/register_file.sv
src/s1c88_core.sv
test/tb_clock.sv
test/tb_s1c88.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_s1c88
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
